/* rtl/swu_addr_gen.sv */
`timescale 1ns/1ps

module swu_addr_gen (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       issue_i,
   input  logic                       frame_done_i,
   input  logic [swu_pkg::CH_W-1:0]   ch_i,
   input  logic [swu_pkg::KW_W-1:0]   kw_i,
   input  logic [swu_pkg::KH_W-1:0]   kh_i,
   input  logic [swu_pkg::OCOL_W-1:0] ofm_col_i,
   input  logic [swu_pkg::OROW_W-1:0] ofm_row_i,
   output logic [swu_pkg::ADDR_W-1:0] rd_addr_o
);

   import swu_pkg::*;

   logic [ADDR_W-1:0] start_q;
   logic [ADDR_W-1:0] row_base_q;
   logic [POS_W-1:0]  col_sum;
   logic [POS_W-1:0]  row_sum;
   logic [POS_W-1:0]  rd_sum;
   logic              window_end;
   logic              last_col;
   logic              last_row;

   // single wrap, every sum stays below twice the buffer size
   function automatic logic [ADDR_W-1:0] wrap(input logic [POS_W-1:0] pos);
      if (pos >= POS_W'(BUFFER_SIZE)) begin
         return ADDR_W'(pos - POS_W'(BUFFER_SIZE));
      end
      return ADDR_W'(pos);
   endfunction

   assign window_end = (ch_i == CH_W'(EFF_CHANNELS - 1)) &&
                       (kw_i == KW_W'(KERNEL_WIDTH - 1)) &&
                       (kh_i == KH_W'(KERNEL_HEIGHT - 1));
   assign last_col   = (ofm_col_i == OCOL_W'(OFM_WIDTH - 1));
   assign last_row   = (ofm_row_i == OROW_W'(OFM_HEIGHT - 1));

   assign col_sum = POS_W'(start_q + COL_STEP);
   assign row_sum = POS_W'(row_base_q + ROW_STEP);
   assign rd_sum  = POS_W'(start_q + kh_i * ROW_WORDS + kw_i * EFF_CHANNELS + ch_i);

   assign rd_addr_o = wrap(rd_sum);

   // start of the window for the current output pixel
   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         start_q    <= '0;
         row_base_q <= '0;
      end else if (issue_i && window_end) begin
         if (!last_col) begin
            start_q <= wrap(col_sum);
         end else if (last_row) begin
            start_q    <= '0;
            row_base_q <= '0;
         end else begin
            start_q    <= wrap(row_sum);
            row_base_q <= wrap(row_sum);
         end
      end
   end

endmodule

/* rtl/swu_line_buffer.sv */
`timescale 1ns/1ps

module swu_line_buffer (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::WORD_W-1:0] in_data_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   input  logic                       row_release_i,
   input  logic                       frame_done_i,
   output logic [swu_pkg::CNT_W-1:0]  written_cnt_o,
   input  logic [swu_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [swu_pkg::WORD_W-1:0] rd_data_o
);

   import swu_pkg::*;

   logic [WORD_W-1:0] mem [BUFFER_SIZE];
   logic [WORD_W-1:0] rd_data_q;
   logic [ADDR_W-1:0] wr_ptr_q;
   logic [CNT_W-1:0]  written_q;
   logic [CNT_W-1:0]  released_q;
   logic [CNT_W-1:0]  held;
   logic              wr_en;

   ////////////////////////////////////////////////////////////
   // input flow control
   ////////////////////////////////////////////////////////////

   // words written but still needed by a window
   assign held = written_q - released_q;

   // stop at a full buffer or at the end of the frame
   assign in_ready_o = (held < CNT_W'(BUFFER_SIZE)) &&
                       (written_q < CNT_W'(FRAME_WORDS));

   assign wr_en = in_valid_i && in_ready_o;

   assign written_cnt_o = written_q;

   ////////////////////////////////////////////////////////////
   // write pointer and frame counts
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr_q   <= '0;
         written_q  <= '0;
         released_q <= '0;
      end else if (frame_done_i) begin
         // next frame starts at entry zero
         wr_ptr_q   <= '0;
         written_q  <= '0;
         released_q <= '0;
      end else begin
         if (wr_en) begin
            written_q <= written_q + 1'b1;
            if (wr_ptr_q == ADDR_W'(BUFFER_SIZE - 1)) begin
               wr_ptr_q <= '0;
            end else begin
               wr_ptr_q <= wr_ptr_q + 1'b1;
            end
         end
         // oldest input row no longer read
         if (row_release_i) begin
            released_q <= released_q + CNT_W'(ROW_WORDS);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // circular memory
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= in_data_i;
      end
      // registered read, data one cycle after the address
      rd_data_q <= mem[rd_addr_i];
   end

   assign rd_data_o = rd_data_q;

endmodule

/* rtl/swu_output_stage.sv */
`timescale 1ns/1ps

module swu_output_stage (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       issue_i,
   input  logic [swu_pkg::WORD_W-1:0] rd_data_i,
   input  logic                       out_ready_i,
   output logic                       pipe_ready_o,
   output logic [swu_pkg::WORD_W-1:0] out_data_o,
   output logic                       out_valid_o,
   output logic                       out_fire_o
);

   import swu_pkg::*;

   // memory output holds a fresh word this cycle
   logic              rd_arrive_q;
   logic              hold_valid_q;
   logic [WORD_W-1:0] hold_data_q;
   logic              out_valid_q;
   logic [WORD_W-1:0] out_data_q;
   logic              stage1_full;
   logic [WORD_W-1:0] stage1_data;
   logic              out_free;

   // stage one is the memory word or its held copy, never both
   assign stage1_full  = rd_arrive_q || hold_valid_q;
   assign stage1_data  = hold_valid_q ? hold_data_q : rd_data_i;
   assign out_free     = !out_valid_q || out_ready_i;
   assign pipe_ready_o = !(stage1_full && out_valid_q && !out_ready_i);
   assign out_fire_o   = out_valid_q && out_ready_i;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_arrive_q  <= 1'b0;
         hold_valid_q <= 1'b0;
         out_valid_q  <= 1'b0;
      end else begin
         rd_arrive_q <= issue_i;
         if (out_free) begin
            out_valid_q  <= stage1_full;
            hold_valid_q <= 1'b0;
         end else if (rd_arrive_q) begin
            // output stalled, keep the word before the memory moves on
            hold_valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (out_free && stage1_full) begin
         out_data_q <= stage1_data;
      end
      if (!out_free && rd_arrive_q) begin
         hold_data_q <= rd_data_i;
      end
   end

   assign out_data_o  = out_data_q;
   assign out_valid_o = out_valid_q;

endmodule

/* rtl/swu_pkg.sv */
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // stream word
   ////////////////////////////////////////////////////////////
   localparam int SIMD          = 2;
   localparam int IP_PRECISION  = 4;
   localparam int IFM_CHANNELS  = 4;
   localparam int EFF_CHANNELS  = IFM_CHANNELS / SIMD;
   localparam int WORD_W        = SIMD * IP_PRECISION;

   ////////////////////////////////////////////////////////////
   // map and kernel geometry
   ////////////////////////////////////////////////////////////
   localparam int IFM_WIDTH     = 4;
   localparam int IFM_HEIGHT    = 4;
   localparam int KERNEL_WIDTH  = 3;
   localparam int KERNEL_HEIGHT = 3;
   localparam int STRIDE        = 1;
   localparam int OFM_WIDTH     = (IFM_WIDTH - KERNEL_WIDTH) / STRIDE + 1;
   localparam int OFM_HEIGHT    = (IFM_HEIGHT - KERNEL_HEIGHT) / STRIDE + 1;

   // derived sizes, all in stream words
   localparam int ROW_WORDS     = IFM_WIDTH * EFF_CHANNELS;
   localparam int FRAME_WORDS   = ROW_WORDS * IFM_HEIGHT;
   localparam int BUFFER_SIZE   = KERNEL_HEIGHT * ROW_WORDS;
   localparam int WINDOW_WORDS  = KERNEL_WIDTH * KERNEL_HEIGHT * EFF_CHANNELS;
   localparam int OUT_WORDS     = OFM_WIDTH * OFM_HEIGHT * WINDOW_WORDS;
   localparam int COL_STEP      = STRIDE * EFF_CHANNELS;
   localparam int ROW_STEP      = STRIDE * ROW_WORDS;

   // widths
   localparam int ADDR_W        = $clog2(BUFFER_SIZE);
   // room for one buffer wrap
   localparam int POS_W         = ADDR_W + 1;
   localparam int CNT_W         = $clog2(FRAME_WORDS + 1);
   localparam int OUT_CNT_W     = $clog2(OUT_WORDS);
   localparam int CH_W          = (EFF_CHANNELS > 1) ? $clog2(EFF_CHANNELS) : 1;
   localparam int KW_W          = (KERNEL_WIDTH > 1) ? $clog2(KERNEL_WIDTH) : 1;
   localparam int KH_W          = (KERNEL_HEIGHT > 1) ? $clog2(KERNEL_HEIGHT) : 1;
   localparam int OCOL_W        = (OFM_WIDTH > 1) ? $clog2(OFM_WIDTH) : 1;
   localparam int OROW_W        = (OFM_HEIGHT > 1) ? $clog2(OFM_HEIGHT) : 1;

endpackage

/* rtl/swu_top.sv */
`timescale 1ns/1ps

module swu_top (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::WORD_W-1:0] in_data_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   output logic [swu_pkg::WORD_W-1:0] out_data_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i
);

   import swu_pkg::*;

   logic [CNT_W-1:0]  written_cnt;
   logic              issue;
   logic [CH_W-1:0]   ch;
   logic [KW_W-1:0]   kw;
   logic [KH_W-1:0]   kh;
   logic [OCOL_W-1:0] ofm_col;
   logic [OROW_W-1:0] ofm_row;
   logic              row_release;
   logic              frame_done;
   logic [ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0] rd_data;
   logic              pipe_ready;
   logic              out_fire;

   ////////////////////////////////////////////////////////////
   // write side and buffer
   ////////////////////////////////////////////////////////////

   swu_line_buffer u_line_buffer (
      .clk           (clk),
      .resetn        (resetn),
      .in_data_i     (in_data_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .row_release_i (row_release),
      .frame_done_i  (frame_done),
      .written_cnt_o (written_cnt),
      .rd_addr_i     (rd_addr),
      .rd_data_o     (rd_data)
   );

   ////////////////////////////////////////////////////////////
   // window sequencing and read address
   ////////////////////////////////////////////////////////////

   swu_window_counter u_window_counter (
      .clk           (clk),
      .resetn        (resetn),
      .written_cnt_i (written_cnt),
      .pipe_ready_i  (pipe_ready),
      .out_fire_i    (out_fire),
      .issue_o       (issue),
      .ch_o          (ch),
      .kw_o          (kw),
      .kh_o          (kh),
      .ofm_col_o     (ofm_col),
      .ofm_row_o     (ofm_row),
      .row_release_o (row_release),
      .frame_done_o  (frame_done)
   );

   swu_addr_gen u_addr_gen (
      .clk          (clk),
      .resetn       (resetn),
      .issue_i      (issue),
      .frame_done_i (frame_done),
      .ch_i         (ch),
      .kw_i         (kw),
      .kh_i         (kh),
      .ofm_col_i    (ofm_col),
      .ofm_row_i    (ofm_row),
      .rd_addr_o    (rd_addr)
   );

   // read pipeline toward the output stream
   swu_output_stage u_output_stage (
      .clk          (clk),
      .resetn       (resetn),
      .issue_i      (issue),
      .rd_data_i    (rd_data),
      .out_ready_i  (out_ready_i),
      .pipe_ready_o (pipe_ready),
      .out_data_o   (out_data_o),
      .out_valid_o  (out_valid_o),
      .out_fire_o   (out_fire)
   );

endmodule

/* rtl/swu_window_counter.sv */
`timescale 1ns/1ps

module swu_window_counter (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::CNT_W-1:0]  written_cnt_i,
   input  logic                       pipe_ready_i,
   input  logic                       out_fire_i,
   output logic                       issue_o,
   output logic [swu_pkg::CH_W-1:0]   ch_o,
   output logic [swu_pkg::KW_W-1:0]   kw_o,
   output logic [swu_pkg::KH_W-1:0]   kh_o,
   output logic [swu_pkg::OCOL_W-1:0] ofm_col_o,
   output logic [swu_pkg::OROW_W-1:0] ofm_row_o,
   output logic                       row_release_o,
   output logic                       frame_done_o
);

   import swu_pkg::*;

   logic [CH_W-1:0]      ch_q;
   logic [KW_W-1:0]      kw_q;
   logic [KH_W-1:0]      kh_q;
   logic [OCOL_W-1:0]    ofm_col_q;
   logic [OROW_W-1:0]    ofm_row_q;
   logic [OUT_CNT_W-1:0] out_cnt_q;
   // every window word of the frame has been issued
   logic                 drained_q;
   logic                 last_ch;
   logic                 last_kw;
   logic                 last_kh;
   logic                 last_col;
   logic                 last_row;
   logic                 window_end;
   logic [CNT_W-1:0]     need_pos;

   assign last_ch    = (ch_q == CH_W'(EFF_CHANNELS - 1));
   assign last_kw    = (kw_q == KW_W'(KERNEL_WIDTH - 1));
   assign last_kh    = (kh_q == KH_W'(KERNEL_HEIGHT - 1));
   assign last_col   = (ofm_col_q == OCOL_W'(OFM_WIDTH - 1));
   assign last_row   = (ofm_row_q == OROW_W'(OFM_HEIGHT - 1));
   assign window_end = last_ch && last_kw && last_kh;

   ////////////////////////////////////////////////////////////
   // issue rule
   ////////////////////////////////////////////////////////////

   // linear frame position of the word this issue reads
   assign need_pos = CNT_W'((ofm_row_q * STRIDE + kh_q) * ROW_WORDS +
                            (ofm_col_q * STRIDE + kw_q) * EFF_CHANNELS + ch_q);

   assign issue_o = pipe_ready_i && !drained_q && (written_cnt_i > need_pos);

   // input row of this output row is done, except on the last row
   assign row_release_o = issue_o && window_end && last_col && !last_row;

   assign frame_done_o = out_fire_i && (out_cnt_q == OUT_CNT_W'(OUT_WORDS - 1));

   ////////////////////////////////////////////////////////////
   // nested trackers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch_q      <= '0;
         kw_q      <= '0;
         kh_q      <= '0;
         ofm_col_q <= '0;
         ofm_row_q <= '0;
      end else if (issue_o) begin
         if (!last_ch) begin
            ch_q <= ch_q + 1'b1;
         end else begin
            ch_q <= '0;
            if (!last_kw) begin
               kw_q <= kw_q + 1'b1;
            end else begin
               kw_q <= '0;
               if (!last_kh) begin
                  kh_q <= kh_q + 1'b1;
               end else begin
                  kh_q <= '0;
                  // window finished, move to the next output pixel
                  if (!last_col) begin
                     ofm_col_q <= ofm_col_q + 1'b1;
                  end else begin
                     ofm_col_q <= '0;
                     ofm_row_q <= last_row ? '0 : ofm_row_q + 1'b1;
                  end
               end
            end
         end
      end
   end

   // frame end tracking on the output side
   always_ff @(posedge clk) begin
      if (!resetn) begin
         drained_q <= 1'b0;
         out_cnt_q <= '0;
      end else if (frame_done_o) begin
         drained_q <= 1'b0;
         out_cnt_q <= '0;
      end else begin
         if (issue_o && window_end && last_col && last_row) begin
            drained_q <= 1'b1;
         end
         if (out_fire_i) begin
            out_cnt_q <= out_cnt_q + 1'b1;
         end
      end
   end

   assign ch_o      = ch_q;
   assign kw_o      = kw_q;
   assign kh_o      = kh_q;
   assign ofm_col_o = ofm_col_q;
   assign ofm_row_o = ofm_row_q;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module swu_tb -f sim.f

./obj_dir/Vswu_tb | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* sim.f */
rtl/swu_pkg.sv
rtl/swu_line_buffer.sv
rtl/swu_window_counter.sv
rtl/swu_addr_gen.sv
rtl/swu_output_stage.sv
rtl/swu_top.sv
tests/swu_tb.sv

/* tests/swu_tb.sv */
`timescale 1ns/1ps

module swu_tb;

   import swu_pkg::*;

   localparam int VEC_WORDS       = FRAME_WORDS + OUT_WORDS;
   localparam int FRAMES          = 4;
   localparam int WATCHDOG_CYCLES = 40 * FRAMES * (FRAME_WORDS + OUT_WORDS);
   localparam int READY_ALWAYS    = 0;
   localparam int READY_RANDOM    = 1;
   localparam int READY_HELD      = 2;

   logic              clk;
   logic              resetn;
   logic [WORD_W-1:0] in_data_i;
   logic              in_valid_i;
   logic              in_ready_o;
   logic [WORD_W-1:0] out_data_o;
   logic              out_valid_o;
   logic              out_ready_i;

   logic [WORD_W-1:0] vec_mem [VEC_WORDS];
   int                value_errs;
   int                protocol_errs;
   int                in_count;
   logic              stall_out;
   logic              prev_wait;
   logic [WORD_W-1:0] prev_data;

   swu_top u_swu_top (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   task automatic compare_value(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
      assert (exp_val == act_val) else begin
         $display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, exp_val, act_val);
         value_errs++;
      end
   endtask

   function automatic void print_counts();
      $display("error counts: value %0d, protocol %0d", value_errs, protocol_errs);
   endfunction

   // one frame of input words with optional idle cycles
   task automatic send_frame(input bit gaps);
      in_count = 0;
      while (in_count < FRAME_WORDS) begin
         @(negedge clk);
         if (gaps && ($urandom % 3 == 0)) begin
            in_valid_i = 1'b0;
         end else begin
            in_valid_i = 1'b1;
            in_data_i  = vec_mem[in_count];
            // in_ready_o only depends on registers, so it holds until the next edge
            if (in_ready_o) begin
               in_count++;
            end
         end
      end
      @(negedge clk);
      in_valid_i = 1'b0;
   endtask

   // collect and compare the 72 window words of one frame
   task automatic receive_frame(input int mode);
      int   k;
      logic rdy;
      k = 0;
      while (k < OUT_WORDS) begin
         @(negedge clk);
         case (mode)
            READY_RANDOM: rdy = ($urandom % 4) != 0;
            READY_HELD:   rdy = !stall_out;
            default:      rdy = 1'b1;
         endcase
         out_ready_i = rdy;
         if (prev_wait) begin
            assert (out_valid_o && (out_data_o == prev_data)) else begin
               $display("output word changed or vanished while out_ready_i was low at %0t ns",
                        $time);
               protocol_errs++;
            end
         end
         if (out_valid_o && rdy) begin
            compare_value("out_data_o", vec_mem[FRAME_WORDS + k], out_data_o);
            k++;
         end
         prev_wait = out_valid_o && !rdy;
         prev_data = out_data_o;
      end
   endtask

   // buffer full with the output stalled
   task automatic check_full_hold();
      wait (in_count == BUFFER_SIZE);
      repeat (2 * BUFFER_SIZE) begin
         @(negedge clk);
         assert (!in_ready_o) else begin
            $display("in_ready_o went high while the buffer was full at %0t ns", $time);
            protocol_errs++;
         end
      end
      compare_value("accepted words", BUFFER_SIZE, in_count);
      @(posedge clk);
      stall_out = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      void'($urandom(32'hd2a6_23b3));
      resetn        = 1'b0;
      in_data_i     = '0;
      in_valid_i    = 1'b0;
      out_ready_i   = 1'b0;
      value_errs    = 0;
      protocol_errs = 0;
      in_count      = 0;
      stall_out     = 1'b0;
      prev_wait     = 1'b0;
      prev_data     = '0;
      $readmemh("tests/swu_vectors.hex", vec_mem);

      repeat (8) @(posedge clk);
      @(negedge clk);
      resetn = 1'b1;

      // state right after reset
      @(negedge clk);
      compare_value("out_valid_o", 1'b0, out_valid_o);
      compare_value("in_ready_o", 1'b1, in_ready_o);

      // two frames back to back without back-pressure
      fork
         begin
            send_frame(1'b0);
            send_frame(1'b0);
         end
         begin
            receive_frame(READY_ALWAYS);
            receive_frame(READY_ALWAYS);
         end
      join

      // random gaps on both sides
      fork
         send_frame(1'b1);
         receive_frame(READY_RANDOM);
      join

      // output held off until the buffer fills
      stall_out = 1'b1;
      fork
         send_frame(1'b0);
         receive_frame(READY_HELD);
         check_full_hold();
      join

      @(negedge clk);
      assert (!out_valid_o) else begin
         $display("an extra output word appeared after the last frame");
         protocol_errs++;
      end

      print_counts();
      if (value_errs + protocol_errs == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      print_counts();
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* tests/swu_vectors.hex */
// words 0 to 31: input frame, row by row, pixel by pixel, channel group last
// words 32 to 103: expected output, kernel row, kernel column, channel group per window
a0 a1 a2 a3 a4 a5 a6 a7
b0 b1 b2 b3 b4 b5 b6 b7
c0 c1 c2 c3 c4 c5 c6 c7
d0 d1 d2 d3 d4 d5 d6 d7
a0 a1 a2 a3 a4 a5
b0 b1 b2 b3 b4 b5
c0 c1 c2 c3 c4 c5
a2 a3 a4 a5 a6 a7
b2 b3 b4 b5 b6 b7
c2 c3 c4 c5 c6 c7
b0 b1 b2 b3 b4 b5
c0 c1 c2 c3 c4 c5
d0 d1 d2 d3 d4 d5
b2 b3 b4 b5 b6 b7
c2 c3 c4 c5 c6 c7
d2 d3 d4 d5 d6 d7
